/* verilog/rv_isa_pkg.sv */
// --------------------
// RISC-V address and instruction widths,
// call and return encodings
// --------------------
package rv_isa_pkg;

  localparam int VADDR_W = 39;

  typedef logic [VADDR_W-1:1] vaddr_t;  // Halfword address, bit 0 dropped
  typedef logic [15:0]        inst16_t;
  typedef logic [31:0]        inst32_t;

  // --------------------
  // Standard encodings
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [2:0] FUNCT3_JALR = 3'b000;
  localparam logic [4:0] REG_RA      = 5'd1;     // Link register x1

  // --------------------
  // Compressed encodings
  localparam logic [1:0] C_OP_JALR     = 2'b10;
  localparam logic [3:0] C_FUNCT4_JALR = 4'b1001;  // c.jalr rs1, links x1

  // Returns through x1
  localparam inst16_t C_RET = 16'h8082;       // c.jr x1
  localparam inst32_t RET   = 32'h0000_8067;  // jalr x0, 0(x1)

endpackage

/* verilog/bp_pkg.sv */
// --------------------
// Predictor transaction structs,
// slot and index types
// --------------------
package bp_pkg;

  localparam int SLOTS = 8;  // Halfwords per fetch block

  typedef logic [SLOTS-1:0]    slot_oh_t;
  typedef logic [2:0]          slot_idx_t;
  typedef logic [SLOTS*16-1:0] fetch_block_t;

  typedef enum logic {
    CALL_RVC = 1'b0,  // Compressed, 1 halfword
    CALL_STD = 1'b1   // Standard, 2 halfwords
  } call_size_t;

  // Fetch response from the cache
  typedef struct packed {
    logic               valid;
    rv_isa_pkg::vaddr_t vaddr;
    fetch_block_t       data;
    slot_oh_t           be;     // One enable per halfword
  } ic_resp_t;

  typedef struct packed {
    logic               valid;
    rv_isa_pkg::vaddr_t vaddr;
  } bp_lookup_t;

  typedef struct packed {
    logic                           valid;
    slot_oh_t                       hit;
    slot_oh_t                       taken;
    rv_isa_pkg::vaddr_t [SLOTS-1:0] targets;
  } bp_pred_t;

  // Commit-side training
  typedef struct packed {
    logic               valid;
    rv_isa_pkg::vaddr_t vaddr;   // Branch halfword address
    rv_isa_pkg::vaddr_t target;
    logic               taken;
    logic               cond;    // Conditional branch
  } bp_update_t;

  typedef struct packed {
    logic               valid;
    slot_idx_t          slot;
    rv_isa_pkg::vaddr_t target;
  } ras_pred_t;

endpackage

/* verilog/bp_call_ret_decode.sv */
// --------------------
// Per-slot call and return decoder
// --------------------
`timescale 1ns/100ps

module bp_call_ret_decode (
  input  bp_pkg::ic_resp_t   i_ic_resp,
  output logic               o_call_valid,
  output bp_pkg::slot_idx_t  o_call_slot,
  output bp_pkg::call_size_t o_call_size,
  output logic               o_ret_valid,
  output bp_pkg::slot_idx_t  o_ret_slot
);

  bp_pkg::slot_oh_t w_call;
  bp_pkg::slot_oh_t w_call_std;  // Standard call form per slot
  bp_pkg::slot_oh_t w_ret;

  // Lowest set bit of a slot mask
  function automatic bp_pkg::slot_idx_t lowest_slot(bp_pkg::slot_oh_t mask);
    bp_pkg::slot_idx_t idx;
    idx = '0;
    for (int i = bp_pkg::SLOTS - 1; i >= 0; i--) begin
      if (mask[i]) idx = bp_pkg::slot_idx_t'(i);
    end
    return idx;
  endfunction

  for (genvar s = 0; s < bp_pkg::SLOTS; s++) begin : g_slot
    rv_isa_pkg::inst16_t w_hw;
    rv_isa_pkg::inst32_t w_word;
    logic                w_rvc_call;
    logic                w_std_call;
    logic                w_slot_en;

    assign w_hw = i_ic_resp.data[s*16 +: 16];
    if (s < bp_pkg::SLOTS - 1) begin : g_word
      assign w_word = i_ic_resp.data[s*16 +: 32];
    end else begin : g_no_word
      assign w_word = '0;  // Standard instruction would cross the block
    end

    assign w_rvc_call = (w_hw[1:0] == rv_isa_pkg::C_OP_JALR) &&
                        (w_hw[15:12] == rv_isa_pkg::C_FUNCT4_JALR) &&
                        (w_hw[11:7] != 5'd0) && (w_hw[6:2] == 5'd0);

    assign w_std_call = (w_word[11:7] == rv_isa_pkg::REG_RA) &&
                        ((w_word[6:0] == rv_isa_pkg::OPC_JAL) ||
                         ((w_word[6:0] == rv_isa_pkg::OPC_JALR) &&
                          (w_word[14:12] == rv_isa_pkg::FUNCT3_JALR)));

    assign w_slot_en     = i_ic_resp.valid && i_ic_resp.be[s];
    assign w_call[s]     = (w_rvc_call || w_std_call) && w_slot_en;
    assign w_call_std[s] = w_std_call;
    assign w_ret[s]      = ((w_hw == rv_isa_pkg::C_RET) || (w_word == rv_isa_pkg::RET)) &&
                           w_slot_en;
  end

  // --------------------
  // Lowest-slot selection
  assign o_call_valid = |w_call;
  assign o_call_slot  = lowest_slot(w_call);
  assign o_call_size  = w_call_std[o_call_slot] ? bp_pkg::CALL_STD : bp_pkg::CALL_RVC;
  assign o_ret_valid  = |w_ret;
  assign o_ret_slot   = lowest_slot(w_ret);

  // Call and return encodings can never share a start slot
  always_comb begin
    if (o_call_valid && o_ret_valid) begin
      assert (o_call_slot != o_ret_slot)
        else $error("call and return decoded at slot %0d", o_call_slot);
    end
  end

endmodule

/* verilog/bp_btb.sv */
// --------------------
// Direct-mapped branch target buffer
// --------------------
`timescale 1ns/100ps

module bp_btb #(
  parameter int BTB_SETS = 16
) (
  input  logic                                          i_clk,
  input  logic                                          i_reset_n,
  input  bp_pkg::bp_lookup_t                            i_lookup,
  input  bp_pkg::bp_update_t                            i_update,
  output bp_pkg::slot_oh_t                              o_hit_oh,
  output rv_isa_pkg::vaddr_t [bp_pkg::SLOTS-1:0]        o_targets,
  output logic                                          o_valid
);

  localparam int VA_W   = $bits(rv_isa_pkg::vaddr_t);
  localparam int SLOT_W = $bits(bp_pkg::slot_idx_t);
  localparam int IDX_W  = $clog2(BTB_SETS);
  localparam int TAG_W  = VA_W - SLOT_W - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // --------------------
  // Storage
  bp_pkg::slot_oh_t   r_valid  [BTB_SETS];
  tag_t               r_tag    [BTB_SETS][bp_pkg::SLOTS];
  rv_isa_pkg::vaddr_t r_target [BTB_SETS][bp_pkg::SLOTS];

  idx_t                                   w_lk_idx;
  tag_t                                   w_lk_tag;
  idx_t                                   w_upd_idx;
  tag_t                                   w_upd_tag;
  bp_pkg::slot_idx_t                      w_upd_slot;
  bp_pkg::slot_oh_t                       w_hit;
  rv_isa_pkg::vaddr_t [bp_pkg::SLOTS-1:0] w_tgt;

  assign w_lk_idx   = i_lookup.vaddr[1+SLOT_W +: IDX_W];
  assign w_lk_tag   = i_lookup.vaddr[VA_W -: TAG_W];
  assign w_upd_idx  = i_update.vaddr[1+SLOT_W +: IDX_W];
  assign w_upd_tag  = i_update.vaddr[VA_W -: TAG_W];
  assign w_upd_slot = i_update.vaddr[SLOT_W:1];  // Halfword within the block

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < BTB_SETS; s++) begin
        r_valid[s] <= '0;
      end
    end else if (i_update.valid) begin
      r_valid[w_upd_idx][w_upd_slot] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_update.valid) begin
      r_tag[w_upd_idx][w_upd_slot]    <= w_upd_tag;
      r_target[w_upd_idx][w_upd_slot] <= i_update.target;
    end
  end

  // --------------------
  // Lookup, all slots of the set at once
  always_comb begin
    for (int s = 0; s < bp_pkg::SLOTS; s++) begin
      w_hit[s] = r_valid[w_lk_idx][s] && (r_tag[w_lk_idx][s] == w_lk_tag);
      w_tgt[s] = w_hit[s] ? r_target[w_lk_idx][s] : '0;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid  <= 1'b0;
      o_hit_oh <= '0;
    end else begin
      o_valid  <= i_lookup.valid;
      o_hit_oh <= i_lookup.valid ? w_hit : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    o_targets <= w_tgt;  // Old contents win over a same-cycle write
  end

endmodule

/* verilog/bp_bimodal.sv */
// --------------------
// Bimodal two-bit counter table
// --------------------
`timescale 1ns/100ps

module bp_bimodal #(
  parameter int BTB_SETS = 16
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  bp_pkg::bp_lookup_t i_lookup,
  input  bp_pkg::bp_update_t i_update,
  input  bp_pkg::slot_oh_t   i_hit_oh,
  output bp_pkg::slot_oh_t   o_taken
);

  localparam int SLOT_W = $bits(bp_pkg::slot_idx_t);
  localparam int IDX_W  = $clog2(BTB_SETS);
  localparam int ENTRIES = BTB_SETS * bp_pkg::SLOTS;

  typedef logic [IDX_W-1:0]        idx_t;
  typedef logic [IDX_W+SLOT_W-1:0] ent_t;  // {set, slot}

  logic [1:0]       r_cnt [ENTRIES];
  bp_pkg::slot_oh_t r_upper;
  idx_t             w_lk_idx;
  ent_t             w_upd_ent;
  logic [1:0]       w_cnt_next;

  assign w_lk_idx  = i_lookup.vaddr[1+SLOT_W +: IDX_W];
  assign w_upd_ent = i_update.vaddr[SLOT_W+IDX_W:1];

  // Saturating step, or strongly taken for jumps
  always_comb begin
    w_cnt_next = r_cnt[w_upd_ent];
    if (!i_update.cond) w_cnt_next = 2'd3;
    else if (i_update.taken && r_cnt[w_upd_ent] != 2'd3) w_cnt_next = r_cnt[w_upd_ent] + 2'd1;
    else if (!i_update.taken && r_cnt[w_upd_ent] != 2'd0) w_cnt_next = r_cnt[w_upd_ent] - 2'd1;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < ENTRIES; e++) begin
        r_cnt[e] <= 2'd1;  // Weakly not taken
      end
    end else if (i_update.valid) begin
      r_cnt[w_upd_ent] <= w_cnt_next;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int s = 0; s < bp_pkg::SLOTS; s++) begin
      r_upper[s] <= r_cnt[{w_lk_idx, bp_pkg::slot_idx_t'(s)}][1];
    end
  end

  assign o_taken = r_upper & i_hit_oh;  // Hits come from the BTB stage

  // A trained counter lands on the side it was pushed toward, never wraps
  a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_update.valid && i_update.cond |=>
      r_cnt[$past(w_upd_ent)] != ($past(i_update.taken) ? 2'd0 : 2'd3));

endmodule

/* verilog/bp_ras.sv */
// --------------------
// Circular return address stack
// --------------------
`timescale 1ns/100ps

module bp_ras #(
  parameter int RAS_DEPTH = 8
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  rv_isa_pkg::vaddr_t i_vaddr,
  input  logic               i_call_valid,
  input  bp_pkg::slot_idx_t  i_call_slot,
  input  bp_pkg::call_size_t i_call_size,
  input  logic               i_ret_valid,
  input  bp_pkg::slot_idx_t  i_ret_slot,
  output bp_pkg::ras_pred_t  o_ras_pred
);

  localparam int PTR_W = $clog2(RAS_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  rv_isa_pkg::vaddr_t r_stack [RAS_DEPTH];
  ptr_t               r_ptr;
  logic               r_valid;
  bp_pkg::slot_idx_t  r_slot;
  rv_isa_pkg::vaddr_t r_target;

  logic               w_push;
  logic               w_pop;
  ptr_t               w_ptr_inc;
  ptr_t               w_ptr_dec;
  rv_isa_pkg::vaddr_t w_ret_addr;

  // Earlier slot in the block decides
  assign w_push = i_call_valid && (!i_ret_valid || i_call_slot < i_ret_slot);
  assign w_pop  = i_ret_valid && (!i_call_valid || i_ret_slot < i_call_slot);

  assign w_ptr_inc  = (r_ptr == ptr_t'(RAS_DEPTH - 1)) ? '0 : r_ptr + 1'b1;
  assign w_ptr_dec  = (r_ptr == '0) ? ptr_t'(RAS_DEPTH - 1) : r_ptr - 1'b1;
  assign w_ret_addr = i_vaddr + rv_isa_pkg::vaddr_t'(i_call_slot) +
                      ((i_call_size == bp_pkg::CALL_STD) ? 38'd2 : 38'd1);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr   <= '0;
      r_valid <= 1'b0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        r_stack[i] <= '0;
      end
    end else begin
      r_valid <= w_pop;
      if (w_push) begin
        r_stack[r_ptr] <= w_ret_addr;  // Overwrites oldest on overflow
        r_ptr          <= w_ptr_inc;
      end else if (w_pop) begin
        r_ptr <= w_ptr_dec;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_slot   <= i_ret_slot;
    r_target <= r_stack[w_ptr_dec];
  end

  assign o_ras_pred = '{valid: r_valid, slot: r_slot, target: r_target};

  a_no_push_pop: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(w_push && w_pop));

endmodule

/* verilog/branch_predictor.sv */
// --------------------
// Next-line predictor top: BTB, bimodal,
// call/return decode and RAS
// --------------------
`timescale 1ns/100ps

module branch_predictor #(
  parameter int BTB_SETS  = 16,
  parameter int RAS_DEPTH = 8
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  bp_pkg::bp_lookup_t i_lookup,
  input  bp_pkg::ic_resp_t   i_ic_resp,
  input  bp_pkg::bp_update_t i_update,
  output bp_pkg::bp_pred_t   o_pred,
  output bp_pkg::ras_pred_t  o_ras_pred
);

  bp_pkg::slot_oh_t                       w_hit_oh;
  bp_pkg::slot_oh_t                       w_taken;
  rv_isa_pkg::vaddr_t [bp_pkg::SLOTS-1:0] w_targets;
  logic                                   w_pred_valid;

  logic               w_call_valid;
  bp_pkg::slot_idx_t  w_call_slot;
  bp_pkg::call_size_t w_call_size;
  logic               w_ret_valid;
  bp_pkg::slot_idx_t  w_ret_slot;

  // --------------------
  // Lookup and training
  bp_btb #(.BTB_SETS(BTB_SETS)) u_btb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_lookup  (i_lookup),
    .i_update  (i_update),
    .o_hit_oh  (w_hit_oh),
    .o_targets (w_targets),
    .o_valid   (w_pred_valid)
  );

  bp_bimodal #(.BTB_SETS(BTB_SETS)) u_bim (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_lookup  (i_lookup),
    .i_update  (i_update),
    .i_hit_oh  (w_hit_oh),
    .o_taken   (w_taken)
  );

  assign o_pred = '{valid: w_pred_valid, hit: w_hit_oh, taken: w_taken, targets: w_targets};

  // --------------------
  // Return stack from fetched bytes
  bp_call_ret_decode u_dec (
    .i_ic_resp    (i_ic_resp),
    .o_call_valid (w_call_valid),
    .o_call_slot  (w_call_slot),
    .o_call_size  (w_call_size),
    .o_ret_valid  (w_ret_valid),
    .o_ret_slot   (w_ret_slot)
  );

  bp_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_vaddr      (i_ic_resp.vaddr),
    .i_call_valid (w_call_valid),
    .i_call_slot  (w_call_slot),
    .i_call_size  (w_call_size),
    .i_ret_valid  (w_ret_valid),
    .i_ret_slot   (w_ret_slot),
    .o_ras_pred   (o_ras_pred)
  );

endmodule

/* tests/tb_clock.sv */
// --------------------
// Testbench clock and reset
// --------------------
`timescale 1ns/100ps

module tb_clock (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk     = 1'b0;
    o_reset_n = 1'b0;
    forever #10 o_clk = ~o_clk;  // 20 ns period
  end

  initial begin
    repeat (4) @(posedge o_clk);
    #2 o_reset_n = 1'b1;
  end

endmodule

/* tests/tb_branch_predictor.sv */
// --------------------
// Trace-driven testbench for the predictor,
// reference model and compare tasks
// --------------------
`timescale 1ns/100ps

module tb_branch_predictor;

  localparam int BTB_SETS  = 16;
  localparam int RAS_DEPTH = 8;
  localparam int IDX_W     = $clog2(BTB_SETS);
  localparam int SLOTS     = bp_pkg::SLOTS;
  localparam int FILLER    = 2;  // Random cycles after each trace line

  logic                  clk;
  logic                  reset_n;
  bp_pkg::bp_lookup_t    lookup;
  bp_pkg::ic_resp_t      ic_resp;
  bp_pkg::bp_update_t    update;
  bp_pkg::bp_pred_t      pred;
  bp_pkg::ras_pred_t     ras_pred;

  int                    cycles = 0;
  int                    cycle_limit = 100000;
  int                    errors = 0;
  logic [31:0]           rng_state = 32'hd1aa;
  string                 trace[$];

  // --------------------
  // Reference model state
  logic                  m_valid  [BTB_SETS][SLOTS];
  rv_isa_pkg::vaddr_t    m_tag    [BTB_SETS][SLOTS];
  rv_isa_pkg::vaddr_t    m_target [BTB_SETS][SLOTS];
  logic [1:0]            m_cnt    [BTB_SETS][SLOTS];
  rv_isa_pkg::vaddr_t    m_stack  [RAS_DEPTH];
  int                    m_ptr;

  tb_clock clk_gen (.o_clk(clk), .o_reset_n(reset_n));

  branch_predictor #(.BTB_SETS(BTB_SETS), .RAS_DEPTH(RAS_DEPTH)) dut0 (
    .i_clk      (clk),
    .i_reset_n  (reset_n),
    .i_lookup   (lookup),
    .i_ic_resp  (ic_resp),
    .i_update   (update),
    .o_pred     (pred),
    .o_ras_pred (ras_pred)
  );

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic fail_run(input string what);
    errors++;
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
    end
  endtask

  task automatic check_pred(input bp_pkg::bp_pred_t exp);
    check_field("o_pred.valid", pred.valid, exp.valid);
    if (exp.valid) begin
      check_field("o_pred.hit", pred.hit, exp.hit);
      check_field("o_pred.taken", pred.taken, exp.taken);
      for (int s = 0; s < SLOTS; s++) begin
        check_field($sformatf("o_pred.targets[%0d]", s), pred.targets[s], exp.targets[s]);
      end
    end
  endtask

  task automatic check_ras(input bp_pkg::ras_pred_t exp);
    check_field("o_ras_pred.valid", ras_pred.valid, exp.valid);
    if (exp.valid) begin
      check_field("o_ras_pred.slot", ras_pred.slot, exp.slot);
      check_field("o_ras_pred.target", ras_pred.target, exp.target);
    end
  endtask

  // --------------------
  // Reference model
  function automatic void model_reset();
    for (int i = 0; i < BTB_SETS; i++) begin
      for (int s = 0; s < SLOTS; s++) begin
        m_valid[i][s]  = 1'b0;
        m_tag[i][s]    = '0;
        m_target[i][s] = '0;
        m_cnt[i][s]    = 2'd1;  // Weakly not taken
      end
    end
    for (int i = 0; i < RAS_DEPTH; i++) m_stack[i] = '0;
    m_ptr = 0;
  endfunction

  function automatic bp_pkg::bp_pred_t predict_lookup(input bp_pkg::bp_lookup_t lk);
    bp_pkg::bp_pred_t   p;
    int                 set;
    rv_isa_pkg::vaddr_t tag;
    p       = '0;
    p.valid = lk.valid;
    set     = int'((lk.vaddr >> 3) % BTB_SETS);
    tag     = lk.vaddr >> (3 + IDX_W);
    if (lk.valid) begin
      for (int s = 0; s < SLOTS; s++) begin
        if (m_valid[set][s] && m_tag[set][s] == tag) begin
          p.hit[s]     = 1'b1;
          p.taken[s]   = m_cnt[set][s][1];
          p.targets[s] = m_target[set][s];
        end
      end
    end
    return p;
  endfunction

  function automatic void model_update(input bp_pkg::bp_update_t up);
    int set;
    int slot;
    set  = int'((up.vaddr >> 3) % BTB_SETS);
    slot = int'(up.vaddr[3:1]);
    if (up.valid) begin
      m_valid[set][slot]  = 1'b1;
      m_tag[set][slot]    = up.vaddr >> (3 + IDX_W);
      m_target[set][slot] = up.target;
      if (!up.cond) m_cnt[set][slot] = 2'd3;  // Jumps go strongly taken
      else if (up.taken && m_cnt[set][slot] < 2'd3) m_cnt[set][slot]++;
      else if (!up.taken && m_cnt[set][slot] > 2'd0) m_cnt[set][slot]--;
    end
  endfunction

  function automatic bp_pkg::ras_pred_t model_fetch(input bp_pkg::ic_resp_t rs);
    bp_pkg::ras_pred_t r;
    logic [143:0]      ext;
    logic [15:0]       hw;
    logic [31:0]       word;
    logic              en;
    int                call_slot;
    int                call_len;
    int                ret_slot;
    r         = '0;
    ext       = {16'h0, rs.data};
    call_slot = -1;
    call_len  = 0;
    ret_slot  = -1;
    // Walk down so the lowest slot is kept
    for (int s = SLOTS - 1; s >= 0; s--) begin
      hw   = ext[s*16 +: 16];
      word = ext[s*16 +: 32];
      en   = rs.valid && rs.be[s];
      if (en && hw[1:0] == 2'b10 && hw[15:12] == 4'b1001 && hw[11:7] != 5'd0 &&
          hw[6:2] == 5'd0) begin
        call_slot = s;
        call_len  = 1;
      end
      if (en && s < SLOTS - 1 && word[11:7] == 5'd1 &&
          (word[6:0] == 7'h6f || (word[6:0] == 7'h67 && word[14:12] == 3'd0))) begin
        call_slot = s;
        call_len  = 2;
      end
      if (en && (hw == 16'h8082 || (s < SLOTS - 1 && word == 32'h0000_8067))) ret_slot = s;
    end
    if (call_slot >= 0 && (ret_slot < 0 || call_slot < ret_slot)) begin
      m_stack[m_ptr] = rs.vaddr + rv_isa_pkg::vaddr_t'(call_slot + call_len);
      m_ptr          = (m_ptr + 1) % RAS_DEPTH;
    end else if (ret_slot >= 0) begin
      m_ptr    = (m_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
      r.valid  = 1'b1;
      r.slot   = bp_pkg::slot_idx_t'(ret_slot);
      r.target = m_stack[m_ptr];
    end
    return r;
  endfunction

  // --------------------
  // One cycle of stimulus, checked on the next edge
  task automatic run_cycle(input bp_pkg::bp_lookup_t lk, input bp_pkg::bp_update_t up,
                           input bp_pkg::ic_resp_t rs);
    bp_pkg::bp_pred_t  exp_pred;
    bp_pkg::ras_pred_t exp_ras;
    lookup   = lk;
    update   = up;
    ic_resp  = rs;
    exp_pred = predict_lookup(lk);  // Read before same-cycle write
    exp_ras  = model_fetch(rs);
    model_update(up);
    @(posedge clk);
    #2;
    check_pred(exp_pred);
    check_ras(exp_ras);
  endtask

  // Random lookup or a fetch block without call/return encodings
  task automatic run_filler();
    bp_pkg::bp_lookup_t lk;
    bp_pkg::ic_resp_t   rs;
    logic [31:0]        r;
    lk = '0;
    rs = '0;
    r  = lcg_next();
    if (r[8]) begin
      lk.valid = 1'b1;
      lk.vaddr = rv_isa_pkg::vaddr_t'(32'h1000 + r[23:16]);
    end else begin
      rs.valid = 1'b1;
      rs.vaddr = rv_isa_pkg::vaddr_t'({r[27:16], 3'b000});
      rs.be    = r[7:0];
      for (int k = 0; k < 4; k++) rs.data[k*32 +: 32] = lcg_next();
      for (int s = 0; s < SLOTS; s++) rs.data[s*16 +: 2] = 2'b00;  // Kills every opcode
    end
    run_cycle(lk, '0, rs);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles", cycles);
      $display("Finished with errors");
      $fatal(1, "run did not finish");
    end
  end

  initial begin
    string                  line;
    string                  body;
    byte                    kind;
    int                     fd;
    int                     n;
    int                     tk;
    int                     cd;
    rv_isa_pkg::vaddr_t     addr;
    rv_isa_pkg::vaddr_t     tgt;
    bp_pkg::slot_oh_t       mask;
    bp_pkg::fetch_block_t   data;
    bp_pkg::bp_lookup_t     lk;
    bp_pkg::bp_update_t     up;
    bp_pkg::ic_resp_t       rs;
    bp_pkg::bp_pred_t       exp;
    lookup  = '0;
    update  = '0;
    ic_resp = '0;
    model_reset();
    fd = $fopen("tests/bp_trace.txt", "r");
    if (fd == 0) fail_run("could not open the trace file tests/bp_trace.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line.len() > 2 && line[0] != "#") trace.push_back(line);
    end
    $fclose(fd);
    cycle_limit = 10 * (trace.size() + FILLER * trace.size()) + 20;
    wait (reset_n);
    @(posedge clk);
    #2;
    foreach (trace[i]) begin
      kind = trace[i][0];
      body = trace[i].substr(2, trace[i].len() - 1);
      lk   = '0;
      up   = '0;
      rs   = '0;
      case (kind)
        "L": begin
          n        = $sscanf(body, "%h %h", addr, mask);
          lk.valid = 1'b1;
          lk.vaddr = addr;
          exp      = predict_lookup(lk);
          if (n != 2) fail_run($sformatf("bad lookup line in trace: %s", trace[i]));
          if (exp.hit !== mask) fail_run($sformatf("trace hit mask disagrees with model: %s",
                                                   trace[i]));
        end
        "U": begin
          n         = $sscanf(body, "%h %h %d %d", addr, tgt, tk, cd);
          up.valid  = 1'b1;
          up.vaddr  = addr;
          up.target = tgt;
          up.taken  = (tk != 0);
          up.cond   = (cd != 0);
          if (n != 4) fail_run($sformatf("bad update line in trace: %s", trace[i]));
        end
        "F": begin
          n        = $sscanf(body, "%h %h %h", addr, mask, data);
          rs.valid = 1'b1;
          rs.vaddr = addr;
          rs.be    = mask;
          rs.data  = data;
          if (n != 3) fail_run($sformatf("bad fetch line in trace: %s", trace[i]));
        end
        default: fail_run($sformatf("unknown kind in trace line: %s", trace[i]));
      endcase
      run_cycle(lk, up, rs);
      repeat (FILLER) run_filler();
    end
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/rv_isa_pkg.sv
verilog/bp_pkg.sv
verilog/bp_call_ret_decode.sv
verilog/bp_btb.sv
verilog/bp_bimodal.sv
verilog/bp_ras.sv
verilog/branch_predictor.sv
tests/tb_clock.sv
tests/tb_branch_predictor.sv

/* Makefile */
TOP = tb_branch_predictor

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

/* tests/bp_trace.txt */
# L <block vaddr> <expected hit mask>    U <vaddr> <target> <taken> <cond>
# F <block vaddr> <byte enables> <data, slot 7 first>   (vaddr in halfwords)
L 1010 00
L 0000 00
U 1013 2000 1 1
L 1010 08
L 1090 00
U 1015 3000 0 1
L 1010 28
U 1015 3000 1 1
U 1015 3000 1 1
L 1010 28
U 1013 2000 0 1
L 1010 28
U 1011 2400 1 0
L 1010 2a
F 4000 ff 00010001000100010001928200010001
F 4100 ff 0001000000ef00010001000100010001
F 4200 fd 00010001000100010001000192820001
F 4300 ff 00010001000180820001000100010001
F 4400 ff 00010001000100010001000100008067
F 4500 ff 00010001000100018082000100019282
F 4600 ff 00010001000192820001000180820001
F 5000 ff 00010001000100010001000100019282
F 5010 ff 00010001000100010001000100019282
F 5020 ff 00010001000100010001000100019282
F 5030 ff 00010001000100010001000100019282
F 5040 ff 00010001000100010001000100019282
F 5050 ff 00010001000100010001000100019282
F 5060 ff 00010001000100010001000100019282
F 5070 ff 00010001000100010001000100019282
F 5080 ff 00010001000100010001000100019282
F 6000 ff 00010001000100010001000100018082
F 6010 ff 00010001000100010001000100018082
F 6020 ff 00010001000100010001000100018082
